//--- ex_cfg.svh
// Widths for the execute stage; EX_XLEN must be a power of two and EX_MUL_STEPS equal to it
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Datapath width of operands and results
`define EX_XLEN 32

// Register address width for 32 architectural registers
`define EX_RADDR_W 5

// One multiplier iteration per operand bit
`define EX_MUL_STEPS `EX_XLEN

`endif

//--- ex_pkg.sv
// Shared enums for the execute stage; encodings are internal and not tied to RV32 funct fields
package ex_pkg;

    // Operation code from decode
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_SLL   = 5'd2,
        OP_SLT   = 5'd3,
        OP_SLTU  = 5'd4,
        OP_XOR   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_OR    = 5'd8,
        OP_AND   = 5'd9,
        OP_MUL   = 5'd10,
        OP_MULH  = 5'd11,
        OP_MULHU = 5'd12,
        OP_BEQ   = 5'd13,
        OP_BNE   = 5'd14,
        OP_BLT   = 5'd15,
        OP_BGE   = 5'd16,
        OP_BLTU  = 5'd17,
        OP_BGEU  = 5'd18,
        OP_JAL   = 5'd19
    } ex_op_e;

    // Which path produces the result
    typedef enum logic [1:0] {
        UNIT_ALU  = 2'd0,
        UNIT_MUL  = 2'd1,
        UNIT_CTRL = 2'd2
    } ex_unit_e;

    // Four-phase req/ack sequencing
    typedef enum logic [1:0] {
        HS_IDLE     = 2'd0,
        HS_BUSY     = 2'd1,
        HS_WAIT_LOW = 2'd2
    } ex_hs_state_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_RUN  = 2'd1,
        MUL_DONE = 2'd2
    } ex_mul_state_e;

endpackage

//--- ex_issue.sv
// Input register holding one item at a time; in_ack_o only rises when the register is free
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_issue import ex_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  ex_op_e                 op_i,
    input  logic [`EX_XLEN-1:0]    opa_i,
    input  logic [`EX_XLEN-1:0]    opb_i,
    input  logic [`EX_XLEN-1:0]    cmpa_i,
    input  logic [`EX_XLEN-1:0]    cmpb_i,
    input  logic [`EX_RADDR_W-1:0] rd_i,
    input  logic [`EX_XLEN-1:0]    pc_next_i,
    input  logic                   in_req_i,
    input  logic                   take_i,
    output logic                   in_ack_o,
    output logic                   valid_o,
    output ex_unit_e               unit_o,
    output ex_op_e                 op_o,
    output logic [`EX_XLEN-1:0]    opa_o,
    output logic [`EX_XLEN-1:0]    opb_o,
    output logic [`EX_XLEN-1:0]    cmpa_o,
    output logic [`EX_XLEN-1:0]    cmpb_o,
    output logic [`EX_RADDR_W-1:0] rd_o,
    output logic [`EX_XLEN-1:0]    pc_next_o,
    output logic                   mul_start_o
);

    ex_hs_state_e hs_state_q;
    ex_unit_e     unit_d;
    logic         capture_w;

    always_comb begin
        case (op_i)
            OP_MUL, OP_MULH, OP_MULHU:                   unit_d = UNIT_MUL;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
            OP_BGEU, OP_JAL:                             unit_d = UNIT_CTRL;
            default:                                     unit_d = UNIT_ALU;
        endcase
    end

    // A slot being taken this cycle counts as free
    assign capture_w = (hs_state_q == HS_IDLE) && in_req_i && (!valid_o || take_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hs_state_q  <= HS_IDLE;
            in_ack_o    <= 1'b0;
            valid_o     <= 1'b0;
            mul_start_o <= 1'b0;
        end else begin
            mul_start_o <= capture_w && (unit_d == UNIT_MUL); // One pulse per multiply
            case (hs_state_q)
                HS_IDLE: begin
                    if (capture_w) begin
                        in_ack_o   <= 1'b1;
                        hs_state_q <= HS_BUSY;
                    end
                end
                HS_BUSY: begin
                    if (!in_req_i) begin // Source has seen the ack
                        in_ack_o   <= 1'b0;
                        hs_state_q <= HS_IDLE;
                    end
                end
                default: begin
                    in_ack_o   <= 1'b0;
                    hs_state_q <= HS_IDLE;
                end
            endcase
            if (capture_w) begin
                valid_o <= 1'b1;
            end else if (take_i) begin
                valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_w) begin
            unit_o    <= unit_d;
            op_o      <= op_i;
            opa_o     <= opa_i;
            opb_o     <= opb_i;
            cmpa_o    <= cmpa_i;
            cmpb_o    <= cmpb_i;
            rd_o      <= rd_i;
            pc_next_o <= pc_next_i;
        end
    end

    // The source keeps its request up until it is acknowledged
    a_req_held_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        (in_req_i && !in_ack_o) |=> in_req_i);

endmodule

//--- ex_alu.sv
// Single-cycle ALU; shift amount is the low log2(EX_XLEN) bits of opb_i, control ops give the sum
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu import ex_pkg::*; (
    input  ex_op_e              op_i,
    input  logic [`EX_XLEN-1:0] opa_i,
    input  logic [`EX_XLEN-1:0] opb_i,
    output logic [`EX_XLEN-1:0] result_o
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0]  shamt_w;
    logic [`EX_XLEN-1:0] sum_w;
    logic                lt_w;
    logic                ltu_w;

    assign shamt_w = opb_i[SHAMT_W-1:0];
    assign sum_w   = opa_i + opb_i;   // Also the branch and jump target
    assign lt_w    = $signed(opa_i) < $signed(opb_i);
    assign ltu_w   = opa_i < opb_i;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = sum_w;
            end
            OP_SUB: begin
                result_o = opa_i - opb_i;
            end
            OP_SLL:  result_o = opa_i << shamt_w;
            OP_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_w};
            OP_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, ltu_w};
            OP_XOR:  result_o = opa_i ^ opb_i;
            OP_SRL:  result_o = opa_i >> shamt_w;
            OP_SRA:  result_o = $unsigned($signed(opa_i) >>> shamt_w); // Sign fill
            OP_OR:   result_o = opa_i | opb_i;
            OP_AND:  result_o = opa_i & opb_i;
            default: result_o = sum_w;  // Branches and JAL
        endcase
    end

endmodule

//--- ex_branch.sv
// Branch condition on the decode-selected compare operands; non-control ops are never taken
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_branch import ex_pkg::*; (
    input  ex_op_e              op_i,
    input  logic [`EX_XLEN-1:0] cmpa_i,
    input  logic [`EX_XLEN-1:0] cmpb_i,
    input  logic [`EX_XLEN-1:0] pc_next_i,
    output logic                taken_o,
    output logic [`EX_XLEN-1:0] link_o
);

    logic eq_w;
    logic lt_w;
    logic ltu_w;

    assign eq_w  = (cmpa_i == cmpb_i);
    assign lt_w  = $signed(cmpa_i) < $signed(cmpb_i);
    assign ltu_w = cmpa_i < cmpb_i;

    always_comb begin
        case (op_i)
            OP_BEQ:  taken_o = eq_w;
            OP_BNE:  taken_o = !eq_w;
            OP_BLT:  taken_o = lt_w;
            OP_BGE:  taken_o = !lt_w;
            OP_BLTU: taken_o = ltu_w;
            OP_BGEU: taken_o = !ltu_w;
            OP_JAL:  taken_o = 1'b1;  // Unconditional
            default: taken_o = 1'b0;
        endcase
    end

    // Return address only for jumps
    assign link_o = (op_i == OP_JAL) ? pc_next_i : '0;

endmodule

//--- ex_mul.sv
// Shift-add multiplier, one bit per cycle; op_i and operands are sampled only on start_i
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mul import ex_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                start_i,
    input  ex_op_e              op_i,
    input  logic [`EX_XLEN-1:0] opa_i,
    input  logic [`EX_XLEN-1:0] opb_i,
    output logic                done_o,
    output logic [`EX_XLEN-1:0] result_o
);

    localparam int CNT_W = $clog2(`EX_MUL_STEPS);

    ex_mul_state_e         state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [2*`EX_XLEN-1:0] acc_q;    // {partial high, remaining multiplier}
    logic [`EX_XLEN-1:0]   mcand_q;
    logic                  neg_q;
    logic                  sel_hi_q;
    logic                  signed_w;
    logic                  a_neg_w;
    logic                  b_neg_w;
    logic [`EX_XLEN:0]     sum_w;
    logic [2*`EX_XLEN-1:0] prod_w;

    assign signed_w = (op_i == OP_MULH);
    assign a_neg_w  = signed_w && opa_i[`EX_XLEN-1];
    assign b_neg_w  = signed_w && opb_i[`EX_XLEN-1];
    assign sum_w    = {1'b0, acc_q[2*`EX_XLEN-1:`EX_XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
        end else if (start_i) begin
            state_q <= MUL_RUN;
        end else if (state_q == MUL_RUN && cnt_q == CNT_W'(`EX_MUL_STEPS - 1)) begin
            state_q <= MUL_DONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q    <= {{`EX_XLEN{1'b0}}, (b_neg_w ? -opb_i : opb_i)};
            mcand_q  <= a_neg_w ? -opa_i : opa_i;  // Most negative value maps to itself
            neg_q    <= a_neg_w ^ b_neg_w;
            sel_hi_q <= (op_i != OP_MUL);
            cnt_q    <= '0;
        end else if (state_q == MUL_RUN) begin
            acc_q <= {sum_w, acc_q[`EX_XLEN-1:1]};
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign prod_w   = neg_q ? (~acc_q + 1'b1) : acc_q;
    assign result_o = sel_hi_q ? prod_w[2*`EX_XLEN-1:`EX_XLEN] : prod_w[`EX_XLEN-1:0];
    // Old result must not look ready for a newly started item
    assign done_o   = (state_q == MUL_DONE) && !start_i;

    a_no_start_while_run: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> (state_q != MUL_RUN));

endmodule

//--- ex_retire.sv
// Writeback register holding one result; it stays stable from wb_req_o rise until wb_ack_i falls
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_retire import ex_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    input  ex_unit_e               unit_i,
    input  ex_op_e                 op_i,
    input  logic [`EX_RADDR_W-1:0] rd_i,
    input  logic [`EX_XLEN-1:0]    alu_result_i,
    input  logic                   mul_done_i,
    input  logic [`EX_XLEN-1:0]    mul_result_i,
    input  logic                   br_taken_i,
    input  logic [`EX_XLEN-1:0]    link_i,
    input  logic                   wb_ack_i,
    output logic                   take_o,
    output logic                   wb_req_o,
    output logic [`EX_RADDR_W-1:0] wb_rd_o,
    output logic                   wb_we_o,
    output logic [`EX_XLEN-1:0]    wb_value_o,
    output logic                   br_taken_o,
    output logic [`EX_XLEN-1:0]    br_target_o
);

    ex_hs_state_e        hs_state_q;
    logic [`EX_XLEN-1:0] value_d;
    logic                we_d;

    always_comb begin
        case (unit_i)
            UNIT_MUL:  value_d = mul_result_i;
            UNIT_CTRL: value_d = link_i;      // Return address for JAL
            default:   value_d = alu_result_i;
        endcase
    end

    assign we_d   = !((unit_i == UNIT_CTRL) && (op_i != OP_JAL)); // Branches write nothing
    assign take_o = valid_i && (hs_state_q == HS_IDLE) && ((unit_i != UNIT_MUL) || mul_done_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hs_state_q <= HS_IDLE;
            wb_we_o    <= 1'b0;
            br_taken_o <= 1'b0;
        end else begin
            case (hs_state_q)
                HS_IDLE:     if (take_o) hs_state_q <= HS_BUSY;
                HS_BUSY:     if (wb_ack_i) hs_state_q <= HS_WAIT_LOW;
                HS_WAIT_LOW: if (!wb_ack_i) hs_state_q <= HS_IDLE;
                default:     hs_state_q <= HS_IDLE;
            endcase
            if (take_o) begin
                wb_we_o    <= we_d;
                br_taken_o <= br_taken_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            wb_rd_o     <= rd_i;
            wb_value_o  <= value_d;
            br_target_o <= {alu_result_i[`EX_XLEN-1:1], 1'b0}; // Target LSB cleared
        end
    end

    assign wb_req_o = (hs_state_q == HS_BUSY);

    // Writeback side may only acknowledge a pending request
    a_ack_only_on_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(wb_ack_i) |-> wb_req_o);

endmodule

//--- ex_stage.sv
// Execute stage top; both boundaries are four-phase req/ack, at most two items in flight
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  ex_op_e                 op_i,
    input  logic [`EX_XLEN-1:0]    opa_i,
    input  logic [`EX_XLEN-1:0]    opb_i,
    input  logic [`EX_XLEN-1:0]    cmpa_i,
    input  logic [`EX_XLEN-1:0]    cmpb_i,
    input  logic [`EX_RADDR_W-1:0] rd_i,
    input  logic [`EX_XLEN-1:0]    pc_next_i,
    input  logic                   in_req_i,
    output logic                   in_ack_o,
    output logic                   wb_req_o,
    output logic [`EX_RADDR_W-1:0] wb_rd_o,
    output logic                   wb_we_o,
    output logic [`EX_XLEN-1:0]    wb_value_o,
    output logic                   br_taken_o,
    output logic [`EX_XLEN-1:0]    br_target_o,
    input  logic                   wb_ack_i
);

    logic                   iss_valid;
    logic                   iss_take;
    ex_unit_e               iss_unit;
    ex_op_e                 iss_op;
    logic [`EX_XLEN-1:0]    iss_opa;
    logic [`EX_XLEN-1:0]    iss_opb;
    logic [`EX_XLEN-1:0]    iss_cmpa;
    logic [`EX_XLEN-1:0]    iss_cmpb;
    logic [`EX_RADDR_W-1:0] iss_rd;
    logic [`EX_XLEN-1:0]    iss_pc_next;
    logic                   mul_start;
    logic                   mul_done;
    logic [`EX_XLEN-1:0]    mul_result;
    logic [`EX_XLEN-1:0]    alu_result;
    logic                   br_taken;
    logic [`EX_XLEN-1:0]    br_link;

    ex_issue u_issue (
        .clk_i(clk_i), .rst_i(rst_i),
        .op_i(op_i), .opa_i(opa_i), .opb_i(opb_i),
        .cmpa_i(cmpa_i), .cmpb_i(cmpb_i), .rd_i(rd_i), .pc_next_i(pc_next_i),
        .in_req_i(in_req_i), .take_i(iss_take), .in_ack_o(in_ack_o),
        .valid_o(iss_valid), .unit_o(iss_unit), .op_o(iss_op),
        .opa_o(iss_opa), .opb_o(iss_opb), .cmpa_o(iss_cmpa), .cmpb_o(iss_cmpb),
        .rd_o(iss_rd), .pc_next_o(iss_pc_next), .mul_start_o(mul_start)
    );

    ex_alu u_alu (
        .op_i(iss_op), .opa_i(iss_opa), .opb_i(iss_opb), .result_o(alu_result)
    );

    ex_branch u_branch (
        .op_i(iss_op), .cmpa_i(iss_cmpa), .cmpb_i(iss_cmpb), .pc_next_i(iss_pc_next),
        .taken_o(br_taken), .link_o(br_link)
    );

    ex_mul u_mul (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(mul_start), .op_i(iss_op),
        .opa_i(iss_opa), .opb_i(iss_opb), .done_o(mul_done), .result_o(mul_result)
    );

    ex_retire u_retire (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(iss_valid), .unit_i(iss_unit), .op_i(iss_op), .rd_i(iss_rd),
        .alu_result_i(alu_result), .mul_done_i(mul_done), .mul_result_i(mul_result),
        .br_taken_i(br_taken), .link_i(br_link), .wb_ack_i(wb_ack_i),
        .take_o(iss_take), .wb_req_o(wb_req_o), .wb_rd_o(wb_rd_o), .wb_we_o(wb_we_o),
        .wb_value_o(wb_value_o), .br_taken_o(br_taken_o), .br_target_o(br_target_o)
    );

endmodule

//--- tb_ex_stage.sv
// Reads ex_input.txt from the project root; expects one writeback per data line in file order
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int MAX_ITEMS = 64;
    localparam int TIMEOUT   = 200;  // Cycles per wait

    logic                   clk_i;
    logic                   rst_i;
    ex_op_e                 op_i;
    logic [`EX_XLEN-1:0]    opa_i;
    logic [`EX_XLEN-1:0]    opb_i;
    logic [`EX_XLEN-1:0]    cmpa_i;
    logic [`EX_XLEN-1:0]    cmpb_i;
    logic [`EX_RADDR_W-1:0] rd_i;
    logic [`EX_XLEN-1:0]    pc_next_i;
    logic                   in_req_i;
    logic                   in_ack_o;
    logic                   wb_req_o;
    logic [`EX_RADDR_W-1:0] wb_rd_o;
    logic                   wb_we_o;
    logic [`EX_XLEN-1:0]    wb_value_o;
    logic                   br_taken_o;
    logic [`EX_XLEN-1:0]    br_target_o;
    logic                   wb_ack_i;

    // Stimulus and expected results with one entry per data line
    ex_op_e                 op_tab         [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    opa_tab        [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    opb_tab        [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    cmpa_tab       [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    cmpb_tab       [MAX_ITEMS];
    logic [`EX_RADDR_W-1:0] rd_tab         [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    pc_next_tab    [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    exp_value_tab  [MAX_ITEMS];
    logic                   exp_we_tab     [MAX_ITEMS];
    logic                   exp_taken_tab  [MAX_ITEMS];
    logic [`EX_XLEN-1:0]    exp_target_tab [MAX_ITEMS];

    int     n_items;
    int     errors;
    int     timeouts;
    int     wb_count;
    integer seed;
    logic   abort;        // Set on the first timeout to stop both sides
    logic   wb_req_prev;

    ex_stage u_ex_stage (
        .clk_i(clk_i), .rst_i(rst_i),
        .op_i(op_i), .opa_i(opa_i), .opb_i(opb_i),
        .cmpa_i(cmpa_i), .cmpb_i(cmpb_i), .rd_i(rd_i), .pc_next_i(pc_next_i),
        .in_req_i(in_req_i), .in_ack_o(in_ack_o),
        .wb_req_o(wb_req_o), .wb_rd_o(wb_rd_o), .wb_we_o(wb_we_o),
        .wb_value_o(wb_value_o), .br_taken_o(br_taken_o), .br_target_o(br_target_o),
        .wb_ack_i(wb_ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Counts each rise of wb_req_o as one writeback
    always @(negedge clk_i) begin
        if (wb_req_o === 1'b1 && wb_req_prev !== 1'b1) begin
            wb_count++;
        end
        wb_req_prev = wb_req_o;
    end

    task automatic load_items();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v_op, v_opa, v_opb, v_cmpa, v_cmpb, v_rd;
        logic [31:0] v_pc, v_value, v_we, v_taken, v_target;
        fd = $fopen("ex_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open ex_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_items < MAX_ITEMS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;  // Column notes and blank lines
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_op, v_opa, v_opb,
                        v_cmpa, v_cmpb, v_rd, v_pc, v_value, v_we, v_taken, v_target);
            if (n != 11) begin
                continue;
            end
            op_tab[n_items]         = ex_op_e'(v_op[4:0]);
            opa_tab[n_items]        = v_opa;
            opb_tab[n_items]        = v_opb;
            cmpa_tab[n_items]       = v_cmpa;
            cmpb_tab[n_items]       = v_cmpb;
            rd_tab[n_items]         = v_rd[`EX_RADDR_W-1:0];
            pc_next_tab[n_items]    = v_pc;
            exp_value_tab[n_items]  = v_value;
            exp_we_tab[n_items]     = v_we[0];
            exp_taken_tab[n_items]  = v_taken[0];
            exp_target_tab[n_items] = v_target;
            n_items++;
        end
        $fclose(fd);
        if (n_items == 0) begin
            $display("No operations found in ex_input.txt");
            errors++;
        end
    endtask

    function automatic bit is_control_op(input ex_op_e op);
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL: is_control_op = 1'b1;
            default: is_control_op = 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // Polls in_ack_o or wb_req_o on falling edges
    task automatic wait_level(input bit input_side, input logic level);
        int   cycles;
        logic seen;
        cycles = 0;
        @(negedge clk_i);
        seen = input_side ? in_ack_o : wb_req_o;
        while (seen !== level && cycles < TIMEOUT && !abort) begin
            @(negedge clk_i);
            cycles++;
            seen = input_side ? in_ack_o : wb_req_o;
        end
        if (seen !== level && !abort) begin
            $display("Timeout: %s did not go to %0d within %0d cycles",
                     input_side ? "in_ack_o" : "wb_req_o", level, TIMEOUT);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic drive_items();
        for (int i = 0; i < n_items && !abort; i++) begin
            @(posedge clk_i);
            op_i      <= op_tab[i];
            opa_i     <= opa_tab[i];
            opb_i     <= opb_tab[i];
            cmpa_i    <= cmpa_tab[i];
            cmpb_i    <= cmpb_tab[i];
            rd_i      <= rd_tab[i];
            pc_next_i <= pc_next_tab[i];
            in_req_i  <= 1'b1;
            wait_level(1'b1, 1'b1);
            @(posedge clk_i);
            in_req_i <= 1'b0;
            wait_level(1'b1, 1'b0);  // Four-phase return to zero
        end
    endtask

    task automatic check_item(input int i);
        check_value("wb_we_o", wb_we_o, exp_we_tab[i]);
        check_value("br_taken_o", br_taken_o, exp_taken_tab[i]);
        if (exp_we_tab[i]) begin
            check_value("wb_rd_o", wb_rd_o, rd_tab[i]);
            check_value("wb_value_o", wb_value_o, exp_value_tab[i]);
        end
        if (is_control_op(op_tab[i])) begin
            check_value("br_target_o", br_target_o, exp_target_tab[i]);
        end
    endtask

    task automatic answer_writebacks();
        int delay;
        for (int i = 0; i < n_items && !abort; i++) begin
            wait_level(1'b0, 1'b1);
            if (!abort) begin
                check_item(i);
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) begin
                    @(negedge clk_i);
                    assert (wb_req_o === 1'b1) else begin
                        $display("wb_req_o dropped before wb_ack_i was raised");
                        errors++;
                    end
                end
                @(posedge clk_i);
                wb_ack_i <= 1'b1;
                wait_level(1'b0, 1'b0);
                @(posedge clk_i);
                wb_ack_i <= 1'b0;
            end
        end
    endtask

    initial begin
        seed        = 32'h42ddacfb;
        n_items     = 0;
        errors      = 0;
        timeouts    = 0;
        wb_count    = 0;
        abort       = 1'b0;
        wb_req_prev = 1'b0;
        rst_i       = 1'b1;
        op_i        = OP_ADD;
        opa_i       = '0;
        opb_i       = '0;
        cmpa_i      = '0;
        cmpb_i      = '0;
        rd_i        = '0;
        pc_next_i   = '0;
        in_req_i    = 1'b0;
        wb_ack_i    = 1'b0;
        load_items();
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("in_ack_o", in_ack_o, 32'h0);  // Idle after reset
        check_value("wb_req_o", wb_req_o, 32'h0);
        fork
            drive_items();
            answer_writebacks();
        join
        // Nothing may be written back twice
        repeat (10) begin
            @(negedge clk_i);
            assert (wb_req_o === 1'b0) else begin
                $display("Extra writeback request after the last item");
                errors++;
            end
        end
        assert (wb_count == n_items) else begin
            $display("Saw %0d writebacks for %0d operations", wb_count, n_items);
            errors++;
        end
        $display("Summary: %0d operations, %0d writebacks, %0d errors, %0d timeouts",
                 n_items, wb_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- ex_input.txt
# op opa opb cmpa cmpb rd pc_next value we taken target, all in hex
# value is checked when we is 1, target only for branch and jump ops
00 7fffffff 00000001 00000000 00000000 01 00000000 80000000 1 0 00000000
01 00000003 00000005 00000000 00000000 02 00000000 fffffffe 1 0 00000000
02 00000001 00000024 00000000 00000000 03 00000000 00000010 1 0 00000000
03 ffffffff 00000001 00000000 00000000 04 00000000 00000001 1 0 00000000
04 ffffffff 00000001 00000000 00000000 05 00000000 00000000 1 0 00000000
05 a5a5a5a5 0f0f0f0f 00000000 00000000 06 00000000 aaaaaaaa 1 0 00000000
06 80000000 00000004 00000000 00000000 07 00000000 08000000 1 0 00000000
07 80000000 00000004 00000000 00000000 08 00000000 f8000000 1 0 00000000
07 f0000000 0000001c 00000000 00000000 09 00000000 ffffffff 1 0 00000000
08 12340000 00005678 00000000 00000000 0a 00000000 12345678 1 0 00000000
09 ff00ff00 0ff00ff0 00000000 00000000 00 00000000 0f000f00 1 0 00000000
0a fffffffd 00000007 00000000 00000000 0b 00000000 ffffffeb 1 0 00000000
0b fffffffd 00000007 00000000 00000000 0c 00000000 ffffffff 1 0 00000000
0c fffffffd 00000007 00000000 00000000 0d 00000000 00000006 1 0 00000000
0b 80000000 80000000 00000000 00000000 0e 00000000 40000000 1 0 00000000
0b 80000000 00000002 00000000 00000000 0f 00000000 ffffffff 1 0 00000000
0a 12345678 00000010 00000000 00000000 10 00000000 23456780 1 0 00000000
0d 00001000 00000021 00000005 00000005 00 00000000 00000000 0 1 00001020
0e 00001000 00000021 00000005 00000005 00 00000000 00000000 0 0 00001020
0f 00002000 fffffff1 ffffffff 00000001 00 00000000 00000000 0 1 00001ff0
10 00002000 fffffff1 ffffffff 00000001 00 00000000 00000000 0 0 00001ff0
10 00001000 00000021 00000007 00000007 00 00000000 00000000 0 1 00001020
11 00002000 fffffff1 ffffffff 00000001 00 00000000 00000000 0 0 00001ff0
12 00002000 fffffff1 ffffffff 00000001 00 00000000 00000000 0 1 00001ff0
11 00001000 00000021 00000001 00000002 00 00000000 00000000 0 1 00001020
13 00000400 00000103 00000000 00000000 01 00000404 00000404 1 1 00000502

//--- all.f
+incdir+.
ex_pkg.sv
ex_issue.sv
ex_alu.sv
ex_branch.sv
ex_mul.sv
ex_retire.sv
ex_stage.sv
tb_ex_stage.sv
